// File: rtl/category_matcher.sv
module category_matcher #(
   type          state_t = logic [2:0],
   parameter int CAT     = 0
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  stream_pkg::char_in_t chr,
   input  stream_pkg::pkt_ctl_t pkt,
   input  logic                 enable,
   output regex_pkg::count_t    count,
   output logic                 fired
);

   // Store to DFA restore path
   state_t restore_data;
   logic   restore_vld;

   // DFA outputs
   state_t dfa_state;
   logic   accept;

   // Keyword seen in the current packet, not yet committed
   logic   spec_match;

   // Save only when the packet is counted
   logic   do_save;

   assign do_save = pkt.eop & enable;
   assign fired   = spec_match;

   // Per-stream DFA state memory
   stream_ctx_store #(
      .entry_t(state_t)
   ) u_store (
      .clk         (clk),
      .rst_n       (rst_n),
      .id          (pkt.id),
      .restore     (pkt.load_state),
      .fresh       (pkt.new_stream),
      .save        (do_save),
      .save_data   (dfa_state),
      .restore_data(restore_data),
      .restore_vld (restore_vld)
   );

   // Keyword automaton for this category
   keyword_dfa #(
      .state_t(state_t),
      .CAT    (CAT)
   ) u_dfa (
      .clk       (clk),
      .rst_n     (rst_n),
      .chr       (chr),
      .load      (restore_vld),
      .load_state(restore_data),
      .state     (dfa_state),
      .accept    (accept)
   );

   // Later assignments take priority
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count      <= '0;
         spec_match <= 1'b0;
      end
      else
      begin
         // New packet starts without a match
         if (pkt.load_state)
            spec_match <= 1'b0;

         // Any accept marks the packet
         if (accept)
            spec_match <= 1'b1;

         if (pkt.eop)
         begin
            if (enable)
               // Commit, at most one per packet
               count <= count + regex_pkg::count_t'(spec_match);
            else
               // Disabled, drop the match, stored state stays as before
               spec_match <= 1'b0;
         end
      end
   end

endmodule

// File: rtl/keyword_dfa.sv
module keyword_dfa #(
   type          state_t = logic [2:0],
   parameter int CAT     = 0
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  stream_pkg::char_in_t chr,
   input  logic                 load,
   input  state_t               load_state,
   output state_t               state,
   output logic                 accept
);

   // Keyword picked by category
   localparam int KW_LEN = regex_pkg::kw_len(CAT);

   // First letter, used to restart after a mismatch
   localparam stream_pkg::char_t FIRST_CH = regex_pkg::kw_char(CAT, 0);

   // Prefix length just before a full match
   localparam state_t LAST_STATE = state_t'(KW_LEN - 1);

   stream_pkg::char_t exp_ch;
   logic              hit;
   logic              done;

   // Character that extends the current prefix
   always_comb
   begin
      exp_ch = regex_pkg::kw_char(CAT, int'(state));
      hit    = (chr.ch == exp_ch);
      done   = hit && (state == LAST_STATE);
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= '0;
         accept <= 1'b0;
      end
      else
      begin
         // Accept lasts a single cycle
         accept <= 1'b0;
         if (load)
            // Restored stream context wins over any character
            state <= load_state;
         else if (chr.vld)
         begin
            if (done)
            begin
               // Full keyword seen, back to idle
               state  <= '0;
               accept <= 1'b1;
            end
            else if (hit)
               state <= state + 1'b1;
            else if (chr.ch == FIRST_CH)
               // No self-overlap in the keywords, so only a restart on the first letter
               state <= state_t'(1);
            else
               state <= '0;
         end
      end
   end

endmodule

// File: rtl/pkt_inspect_top.sv
module pkt_inspect_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  stream_pkg::char_in_t   chr,
   input  stream_pkg::pkt_ctl_t   pkt,
   input  regex_pkg::cat_enable_t enable,
   output regex_pkg::cat_counts_t counts,
   output regex_pkg::cat_fired_t  fired
);

   // rlogin category
   // Same character and packet controls for both matchers
   category_matcher #(
      .state_t(regex_pkg::rlogin_state_t),
      .CAT    (regex_pkg::CAT_RLOGIN)
   ) u_rlogin (
      .clk   (clk),
      .rst_n (rst_n),
      .chr   (chr),
      .pkt   (pkt),
      .enable(enable[regex_pkg::CAT_RLOGIN]),
      .count (counts.rlogin),
      .fired (fired[regex_pkg::CAT_RLOGIN])
   );

   // Anonymous ftp login category
   // Wider state for the nine-letter keyword
   category_matcher #(
      .state_t(regex_pkg::ftp_anon_state_t),
      .CAT    (regex_pkg::CAT_FTP_ANON)
   ) u_ftp_anon (
      .clk   (clk),
      .rst_n (rst_n),
      .chr   (chr),
      .pkt   (pkt),
      .enable(enable[regex_pkg::CAT_FTP_ANON]),
      .count (counts.ftp_anon),
      .fired (fired[regex_pkg::CAT_FTP_ANON])
   );

endmodule

// File: rtl/regex_pkg.sv
package regex_pkg;

   // Keyword categories
   localparam int NUM_CAT      = 2;
   localparam int CAT_RLOGIN   = 0;
   localparam int CAT_FTP_ANON = 1;

   // Per-category packet counter
   localparam int COUNT_W = 16;
   typedef logic [COUNT_W-1:0] count_t;

   // Keywords, first letter sits in the highest byte
   localparam int KW_RLOGIN_LEN   = 6;
   localparam int KW_FTP_ANON_LEN = 9;
   localparam stream_pkg::char_t [KW_RLOGIN_LEN-1:0]   KW_RLOGIN   = "rlogin";
   localparam stream_pkg::char_t [KW_FTP_ANON_LEN-1:0] KW_FTP_ANON = "anonymous";

   // DFA state is the matched prefix length, never reaches the full length
   typedef logic [2:0] rlogin_state_t;
   typedef logic [3:0] ftp_anon_state_t;

   typedef logic [NUM_CAT-1:0] cat_enable_t;
   typedef logic [NUM_CAT-1:0] cat_fired_t;

   typedef struct packed {
      count_t rlogin;
      count_t ftp_anon;
   } cat_counts_t;

   // Keyword length of a category
   function automatic int kw_len(input int cat);
      return (cat == CAT_RLOGIN) ? KW_RLOGIN_LEN : KW_FTP_ANON_LEN;
   endfunction

   // Character at prefix position pos, counted from the first letter
   // Positions past the end give zero, which never matches payload text here
   function automatic stream_pkg::char_t kw_char(input int cat, input int pos);
      if (pos >= kw_len(cat))
         return '0;
      if (cat == CAT_RLOGIN)
         return KW_RLOGIN[KW_RLOGIN_LEN-1-pos];
      return KW_FTP_ANON[KW_FTP_ANON_LEN-1-pos];
   endfunction

endpackage

// File: rtl/stream_ctx_store.sv
module stream_ctx_store #(
   type entry_t = logic [2:0]
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  stream_pkg::stream_id_t id,
   input  logic                   restore,
   input  logic                   fresh,
   input  logic                   save,
   input  entry_t                 save_data,
   output entry_t                 restore_data,
   output logic                   restore_vld
);

   // One saved DFA state per stream
   entry_t mem [stream_pkg::NUM_STREAMS];

   // Write back at end of an enabled packet
   always_ff @(posedge clk)
   begin
      if (save)
         mem[id] <= save_data;
   end

   // Registered restore, new streams start from the idle state
   always_ff @(posedge clk)
   begin
      if (restore)
         restore_data <= fresh ? entry_t'(0) : mem[id];
   end

   // Valid pulse lines up with restore_data
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         restore_vld <= 1'b0;
      else
         restore_vld <= restore;
   end

endmodule

// File: rtl/stream_pkg.sv
package stream_pkg;

   // Streams tracked by the inspector, one saved context each
   localparam int NUM_STREAMS = 64;

   // Stream id width follows the stream count
   localparam int STREAM_ID_W = $clog2(NUM_STREAMS);

   typedef logic [STREAM_ID_W-1:0] stream_id_t;

   // One payload byte
   typedef logic [7:0] char_t;

   // Character strobe with its byte
   typedef struct packed {
      logic  vld;
      char_t ch;
   } char_in_t;

   // Packet framing controls
   // new_stream only counts together with load_state
   // id must stay stable from load_state up to and including eop
   typedef struct packed {
      logic       load_state;
      logic       new_stream;
      logic       eop;
      stream_id_t id;
   } pkt_ctl_t;

endpackage

// File: run.sh
#!/bin/sh
# Build, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module pkt_inspect_tb \
   > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vpkt_inspect_tb > sim.log 2>&1
cat sim.log
grep -q "^All tests passed!$" sim.log && exit 0 || exit 1

// File: tb.f
rtl/stream_pkg.sv
rtl/regex_pkg.sv
rtl/stream_ctx_store.sv
rtl/keyword_dfa.sv
rtl/category_matcher.sv
rtl/pkt_inspect_top.sv
tests/pkt_inspect_properties.sv
tests/pkt_inspect_tb.sv

// File: tests/pkt_inspect_properties.sv
module pkt_inspect_properties (
   input logic                   clk,
   input logic                   rst_n,
   input stream_pkg::char_in_t   chr,
   input stream_pkg::pkt_ctl_t   pkt,
   input regex_pkg::cat_counts_t counts,
   input regex_pkg::cat_fired_t  fired
);

   // The restored state reaches the DFA two cycles after load_state
   // A character earlier than that would step a stale state or be lost to the load
   no_early_char: assert property (@(posedge clk) disable iff (!rst_n)
      chr.vld |-> (!pkt.load_state && !$past(pkt.load_state)))
      else $error("character strobe within two cycles of load_state");

   // Speculative flags are dropped at packet start
   fired_cleared: assert property (@(posedge clk) disable iff (!rst_n)
      $past(pkt.load_state) |-> (fired == '0))
      else $error("fired not cleared after load_state");

   // A count only moves right after eop, and by one
   rlogin_step: assert property (@(posedge clk) disable iff (!rst_n)
      (counts.rlogin != $past(counts.rlogin)) |->
         ($past(pkt.eop) &&
          counts.rlogin == regex_pkg::count_t'($past(counts.rlogin) + 1)))
      else $error("rlogin count changed by more than one per eop");

   ftp_anon_step: assert property (@(posedge clk) disable iff (!rst_n)
      (counts.ftp_anon != $past(counts.ftp_anon)) |->
         ($past(pkt.eop) &&
          counts.ftp_anon == regex_pkg::count_t'($past(counts.ftp_anon) + 1)))
      else $error("ftp_anon count changed by more than one per eop");

endmodule

// File: tests/pkt_inspect_tb.sv
module pkt_inspect_tb;

   // Per-packet cycles beside the characters: load, gap, two tail cycles, eop, check
   localparam int PKT_OVERHEAD       = 8;
   localparam int DIRECTED_PKTS      = 13;
   localparam int DIRECTED_MAX_CHARS = 24;
   localparam int RAND_PKTS          = 16;
   localparam int RAND_MAX_CHARS     = 20;
   localparam int RESET_CYCLES       = 16;
   localparam int TIMEOUT_CYCLES     = RESET_CYCLES
      + DIRECTED_PKTS * (DIRECTED_MAX_CHARS + PKT_OVERHEAD)
      + RAND_PKTS * (RAND_MAX_CHARS + PKT_OVERHEAD) + 200;

   logic                   clk;
   logic                   rst_n;
   stream_pkg::char_in_t   chr;
   stream_pkg::pkt_ctl_t   pkt;
   regex_pkg::cat_enable_t enable;
   regex_pkg::cat_counts_t counts;
   regex_pkg::cat_fired_t  fired;

   // Reference model state
   string                  kw_text [regex_pkg::NUM_CAT];
   int                     saved_prefix [regex_pkg::NUM_CAT][stream_pkg::NUM_STREAMS];
   regex_pkg::cat_counts_t exp_counts;

   // Characters of the next packet
   stream_pkg::char_t      payload_q [$];

   int seed = 32'h68a8;
   int n_checks = 0;
   int n_errors = 0;
   int cycle_cnt = 0;

   pkt_inspect_top i_dut (
      .clk   (clk),
      .rst_n (rst_n),
      .chr   (chr),
      .pkt   (pkt),
      .enable(enable),
      .counts(counts),
      .fired (fired)
   );

   bind pkt_inspect_top pkt_inspect_properties u_props (
      .clk   (clk),
      .rst_n (rst_n),
      .chr   (chr),
      .pkt   (pkt),
      .counts(counts),
      .fired (fired)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Hard stop in case the run never reaches its end
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic check_counts(input regex_pkg::cat_counts_t exp,
                               input regex_pkg::cat_counts_t act);
      n_checks++;
      if (act.rlogin !== exp.rlogin)
      begin
         n_errors++;
         $display("Error: counts.rlogin expected 0x%h got 0x%h", exp.rlogin, act.rlogin);
      end
      if (act.ftp_anon !== exp.ftp_anon)
      begin
         n_errors++;
         $display("Error: counts.ftp_anon expected 0x%h got 0x%h",
                  exp.ftp_anon, act.ftp_anon);
      end
   endtask

   task automatic check_fired(input regex_pkg::cat_fired_t exp,
                              input regex_pkg::cat_fired_t act);
      n_checks++;
      if (act !== exp)
      begin
         n_errors++;
         $display("Error: fired expected 0x%h got 0x%h", exp, act);
      end
   endtask

   // Keyword restart rule, no keyword overlaps itself
   function automatic int next_prefix(input int cat, input int st,
                                      input stream_pkg::char_t ch);
      string kw;
      kw = kw_text[cat];
      if (ch == kw[st])
         return st + 1;
      if (ch == kw[0])
         return 1;
      return 0;
   endfunction

   // Walks the payload per category and commits like the matcher does at eop
   task automatic model_packet(input stream_pkg::stream_id_t id, input logic fresh,
                               input regex_pkg::cat_enable_t en,
                               output regex_pkg::cat_fired_t hit);
      int st;
      hit = '0;
      for (int cat = 0; cat < regex_pkg::NUM_CAT; cat++)
      begin
         st = fresh ? 0 : saved_prefix[cat][id];
         foreach (payload_q[i])
         begin
            st = next_prefix(cat, st, payload_q[i]);
            if (st == kw_text[cat].len())
            begin
               hit[cat] = 1'b1;
               st = 0;
            end
         end
         if (en[cat])
         begin
            saved_prefix[cat][id] = st;
            if (hit[cat] && cat == regex_pkg::CAT_RLOGIN)
               exp_counts.rlogin = exp_counts.rlogin + 1'b1;
            if (hit[cat] && cat == regex_pkg::CAT_FTP_ANON)
               exp_counts.ftp_anon = exp_counts.ftp_anon + 1'b1;
         end
      end
   endtask

   task automatic add_text(input string s, input int from, input int upto);
      for (int i = from; i < upto; i++)
         payload_q.push_back(s[i]);
   endtask

   task automatic set_payload(input string s);
      payload_q.delete();
      add_text(s, 0, s.len());
   endtask

   // Digits only, none of them is a keyword letter
   task automatic add_filler();
      int n;
      n = $unsigned($random(seed)) % 6;
      repeat (n)
         payload_q.push_back(stream_pkg::char_t'(8'h30 + $unsigned($random(seed)) % 10));
   endtask

   // One packet of payload_q on stream id, checked at eop and one cycle later
   task automatic send_packet(input stream_pkg::stream_id_t id, input logic fresh,
                              input regex_pkg::cat_enable_t en);
      regex_pkg::cat_fired_t exp_fired;
      model_packet(id, fresh, en, exp_fired);
      @(posedge clk);
      pkt.load_state <= 1'b1;
      pkt.new_stream <= fresh;
      pkt.id         <= id;
      enable         <= en;
      @(posedge clk);
      pkt.load_state <= 1'b0;
      pkt.new_stream <= 1'b0;
      // Restored state lands in the DFA at the end of this cycle
      foreach (payload_q[i])
      begin
         @(posedge clk);
         chr.vld <= 1'b1;
         chr.ch  <= payload_q[i];
      end
      @(posedge clk);
      chr.vld <= 1'b0;
      @(posedge clk);
      pkt.eop <= 1'b1;
      // Flags of the whole packet are up during eop
      @(negedge clk);
      check_fired(exp_fired, fired);
      @(posedge clk);
      pkt.eop <= 1'b0;
      @(negedge clk);
      check_counts(exp_counts, counts);
      check_fired(exp_fired & en, fired);
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (n_errors == errs_before)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, n_errors - errs_before);
   endtask

   task automatic test_reset_idle();
      int errs;
      errs = n_errors;
      @(negedge clk);
      check_counts('0, counts);
      check_fired('0, fired);
      set_payload("hello world");
      send_packet(6'd0, 1'b1, 2'b11);
      report_test("reset_idle", errs);
   endtask

   task automatic test_rlogin_twice();
      int errs;
      errs = n_errors;
      set_payload("rlogin xx rlogin");
      send_packet(6'd1, 1'b1, 2'b11);
      report_test("rlogin_twice", errs);
   endtask

   // Second half only joins when the saved context is restored
   task automatic test_anon_split();
      int errs;
      errs = n_errors;
      set_payload("xxanon");
      send_packet(6'd3, 1'b1, 2'b11);
      set_payload("ymous zz");
      send_packet(6'd3, 1'b0, 2'b11);
      set_payload("anon");
      send_packet(6'd4, 1'b1, 2'b11);
      set_payload("ymous");
      send_packet(6'd4, 1'b1, 2'b11);
      report_test("anon_split", errs);
   endtask

   task automatic test_interleaved_streams();
      int errs;
      errs = n_errors;
      set_payload("rlo");
      send_packet(6'd10, 1'b1, 2'b11);
      set_payload("xrl");
      send_packet(6'd11, 1'b1, 2'b11);
      set_payload("gin");
      send_packet(6'd10, 1'b0, 2'b11);
      set_payload("ogin");
      send_packet(6'd11, 1'b0, 2'b11);
      report_test("interleaved_streams", errs);
   endtask

   // Disabled packet is dropped and leaves the saved prefix alone
   task automatic test_disabled();
      int errs;
      errs = n_errors;
      set_payload("abc");
      send_packet(6'd5, 1'b1, 2'b11);
      set_payload("rlogin rlo");
      send_packet(6'd5, 1'b0, 2'b00);
      set_payload("gin");
      send_packet(6'd5, 1'b0, 2'b11);
      report_test("disabled", errs);
   endtask

   task automatic test_random_filler();
      int    errs;
      int    mode;
      int    cat;
      int    cut;
      string kw;
      errs = n_errors;
      for (int p = 0; p < RAND_PKTS; p++)
      begin
         payload_q.delete();
         mode = $unsigned($random(seed)) % 4;
         cat  = $unsigned($random(seed)) % 2;
         kw   = kw_text[cat];
         cut  = 1 + $unsigned($random(seed)) % (kw.len() - 1);
         // Mode 0 whole keyword, 1 ends on a prefix, 2 starts with a suffix, 3 filler only
         if (mode != 2)
            add_filler();
         if (mode == 0)
            add_text(kw, 0, kw.len());
         else if (mode == 1)
            add_text(kw, 0, cut);
         else if (mode == 2)
            add_text(kw, cut, kw.len());
         if (mode != 1)
            add_filler();
         send_packet(stream_pkg::stream_id_t'(20 + p % 4), p < 4, 2'b11);
      end
      report_test("random_filler", errs);
   endtask

   initial
   begin
      kw_text[regex_pkg::CAT_RLOGIN]   = "rlogin";
      kw_text[regex_pkg::CAT_FTP_ANON] = "anonymous";
      exp_counts = '0;
      rst_n  = 1'b0;
      chr    = '0;
      pkt    = '0;
      enable = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      test_reset_idle();
      test_rlogin_twice();
      test_anon_split();
      test_interleaved_streams();
      test_disabled();
      test_random_filler();

      $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule
